// File: dv/router_arbiter_testdata.txt
// first line: router position as x y
// then per packet: in_port dest_x dest_y expected_out phase, ports 0 N 1 S 2 W 3 E 4 L, ff ends
2 2
// phase 1, queued before reset release
0 3 1 3 1
1 4 2 3 1
2 3 3 3 1
4 2 3 0 1
3 0 2 2 1
0 2 2 4 1
2 2 0 1 1
4 1 1 2 1
// phase 2, pushed after random gaps
1 2 4 0 2
3 2 2 4 2
0 0 0 2 2
4 3 0 3 2
2 2 3 0 2
3 2 1 1 2
1 1 3 2 2
4 2 0 1 2
ff

// File: build.f
+incdir+rtl
rtl/noc_types_pkg.sv
rtl/arb_ctrl_pkg.sv
rtl/route_unit.sv
rtl/out_arbiter.sv
rtl/grant_merge.sv
rtl/router_arbiter.sv
dv/router_arbiter_assertions.sv
dv/router_arbiter_tb.sv

// File: dv/router_arbiter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module router_arbiter_tb;
	import noc_types_pkg::*;

	localparam int MAX_PKT   = 32;
	localparam int CRD_SLOTS = 64;

	typedef struct packed {
		logic [2:0] in_port;
		xy_t        dest;
		logic [2:0] out_port; // expected output from the data line.
		logic       late;     // phase 2, pushed after reset.
	} pkt_t;

	logic                       clk;
	logic                       arst_n;
	xy_t                        yx_pos;
	port_vec_t                  empty_n;
	xy_t [`NOC_PORTS-1:0]       head_dest;
	port_vec_t                  credit;
	port_vec_t                  rd;
	port_vec_t                  out_valid;
	port_dir_e [`NOC_PORTS-1:0] out_sel;

	logic [7:0] tdata [0:255];
	pkt_t       pkts [0:MAX_PKT-1];
	int         in_q [`NOC_PORTS][0:MAX_PKT-1]; // packet indices per input buffer.
	int         q_head [`NOC_PORTS];
	int         q_tail [`NOC_PORTS];
	int         flit_idx [`NOC_PORTS];           // flits of the head packet already sent.
	int         late_list [0:MAX_PKT-1];
	int         crd_due [`NOC_PORTS][0:CRD_SLOTS-1];
	int         crd_wr [`NOC_PORTS];
	int         crd_rd [`NOC_PORTS];
	int         sent_cnt [`NOC_PORTS];
	int         ret_cnt [`NOC_PORTS];
	int         exp_lock [`NOC_PORTS];
	int         exp_ptr [`NOC_PORTS];
	logic [`NOC_PORTS-1:0] exp_busy;
	int         npkt, late_cnt, late_rd, delivered;
	int         cyc, limit, check_cnt, err_cnt;
	logic       rng_seeded;
	int         since_rst = 0;
	int         next_push;

	router_arbiter dut0 (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.yx_pos_i    (yx_pos),
		.empty_n_i   (empty_n),
		.head_dest_i (head_dest),
		.credit_i    (credit),
		.read_o      (rd),
		.out_valid_o (out_valid),
		.out_sel_o   (out_sel)
	);

	always #5 clk = ~clk;

	task automatic log_mismatch(input string msg);
		err_cnt++;
		$display("FAIL %0t ns: %s", $time, msg);
	endtask

	// x first, then y, same as the router's routing rule.
	function automatic int xy_expected_dir(input xy_t dest, input xy_t pos);
		int dir;
		if (dest.x > pos.x) dir = 3;
		else if (dest.x < pos.x) dir = 2;
		else if (dest.y > pos.y) dir = 0;
		else if (dest.y < pos.y) dir = 1;
		else dir = 4;
		return dir;
	endfunction

	function automatic logic header_waits(input int i, input int o);
		logic w;
		w = 1'b0;
		if (q_head[i] != q_tail[i] && flit_idx[i] == 0) begin
			w = (int'(pkts[in_q[i][q_head[i]]].out_port) == o);
		end
		return w;
	endfunction

	task automatic load_testdata();
		int   idx;
		pkt_t pk;
		for (int a = 0; a < 256; a++) begin
			tdata[a] = 8'hff;
		end
		$readmemh("dv/router_arbiter_testdata.txt", tdata);
		yx_pos.x = tdata[0][`NOC_COORD_W-1:0];
		yx_pos.y = tdata[1][`NOC_COORD_W-1:0];
		idx      = 2;
		while (tdata[idx] != 8'hff && npkt < MAX_PKT) begin
			pk.in_port  = tdata[idx][2:0];
			pk.dest.x   = tdata[idx+1][`NOC_COORD_W-1:0];
			pk.dest.y   = tdata[idx+2][`NOC_COORD_W-1:0];
			pk.out_port = tdata[idx+3][2:0];
			pk.late     = (tdata[idx+4] == 8'd2);
			check_cnt++;
			if (xy_expected_dir(pk.dest, yx_pos) != int'(pk.out_port)) begin
				log_mismatch($sformatf("packet %0d data line names output %0d, xy rule gives %0d",
					npkt, pk.out_port, xy_expected_dir(pk.dest, yx_pos)));
			end
			pkts[npkt] = pk;
			if (pk.late) begin
				late_list[late_cnt] = npkt;
				late_cnt++;
			end else begin
				in_q[pk.in_port][q_tail[pk.in_port]] = npkt;
				q_tail[pk.in_port]++;
			end
			npkt++;
			idx += 5;
		end
		if (npkt == 0) begin
			err_cnt++;
			$display("ERROR: no packets found in dv/router_arbiter_testdata.txt");
		end
	endtask

	// buffer heads and returned credits, applied just after the clock edge.
	task automatic drive_inputs();
		int p;
		for (int i = 0; i < `NOC_PORTS; i++) begin
			empty_n[i]   = (q_head[i] != q_tail[i]);
			head_dest[i] = '0;
			if (empty_n[i]) begin
				p            = in_q[i][q_head[i]];
				head_dest[i] = pkts[p].dest;
			end
		end
		for (int o = 0; o < `NOC_PORTS; o++) begin
			credit[o] = 1'b0;
			if (arst_n && crd_rd[o] != crd_wr[o] && crd_due[o][crd_rd[o] % CRD_SLOTS] <= cyc) begin
				credit[o] = 1'b1;
				crd_rd[o]++;
				ret_cnt[o]++;
			end
		end
	endtask

	task automatic flit_sent(input int o, input int i);
		int p;
		p = in_q[i][q_head[i]];
		check_cnt++;
		if (q_head[i] == q_tail[i]) begin
			log_mismatch($sformatf("output %0d sent from empty input %0d", o, i));
		end else begin
			if (int'(pkts[p].out_port) != o) begin
				log_mismatch($sformatf("packet %0d left on output %0d, expected %0d",
					p, o, pkts[p].out_port));
			end
			sent_cnt[o]++;
			crd_due[o][crd_wr[o] % CRD_SLOTS] = cyc + 1 + $urandom_range(6, 0);
			crd_wr[o]++;
			check_cnt++;
			if (sent_cnt[o] - ret_cnt[o] > `NOC_CREDITS) begin
				log_mismatch($sformatf("output %0d has %0d flits in flight", o,
					sent_cnt[o] - ret_cnt[o]));
			end
			flit_idx[i]++;
			if (flit_idx[i] == `NOC_PKT_FLITS) begin // tail flit, output frees up.
				flit_idx[i] = 0;
				q_head[i]++;
				delivered++;
				exp_busy[o] = 1'b0;
				exp_ptr[o]  = (i + 1) % `NOC_PORTS;
			end
		end
	endtask

	task automatic step_model();
		logic [`NOC_PORTS-1:0] busy_now;
		logic                  found;
		int                    i, hits;
		busy_now = exp_busy;
		for (int o = 0; o < `NOC_PORTS; o++) begin
			found = 1'b0;
			for (int k = 0; k < `NOC_PORTS; k++) begin
				i = (exp_ptr[o] + k) % `NOC_PORTS;
				if (!busy_now[o] && !found && i != o && header_waits(i, o)) begin
					found       = 1'b1;
					exp_busy[o] = 1'b1;
					exp_lock[o] = i;
				end
			end
		end
		for (int n = 0; n < `NOC_PORTS; n++) begin
			hits = 0;
			for (int o = 0; o < `NOC_PORTS; o++) begin
				if (out_valid[o] && int'(out_sel[o]) == n) hits++;
			end
			check_cnt++;
			if (hits != int'(rd[n])) begin
				log_mismatch($sformatf("input %0d read %0b but matches %0d outputs", n, rd[n], hits));
			end
		end
		for (int o = 0; o < `NOC_PORTS; o++) begin
			if (out_valid[o]) begin
				check_cnt++;
				if (!busy_now[o]) begin
					log_mismatch($sformatf("output %0d valid without an owning packet", o));
				end else if (int'(out_sel[o]) != exp_lock[o]) begin
					log_mismatch($sformatf("output %0d select %0d, expected input %0d",
						o, out_sel[o], exp_lock[o]));
				end else begin
					flit_sent(o, exp_lock[o]);
				end
			end
		end
	endtask

	task automatic push_late();
		int p;
		if (late_rd < late_cnt && since_rst >= next_push) begin
			p = late_list[late_rd];
			in_q[pkts[p].in_port][q_tail[pkts[p].in_port]] = p;
			q_tail[pkts[p].in_port]++;
			late_rd++;
			next_push = since_rst + $urandom_range(12, 1);
		end
	endtask

	// outputs are settled half a period after the edge.
	always @(negedge clk) begin
		if (!rng_seeded) begin
			rng_seeded = 1'b1;
			next_push  = 1 + int'($urandom(32'h1f57_4b89) % 12); // seeds every later draw here.
		end
		if (!arst_n) since_rst = 0;
		else since_rst++;
		if (since_rst <= 1) begin
			check_cnt++;
			if (rd != '0 || out_valid != '0) begin
				log_mismatch($sformatf("read %b valid %b during or right after reset", rd, out_valid));
			end
		end
		if (arst_n) begin
			step_model();
			push_late();
		end
	end

	initial begin
		rng_seeded = 1'b0;
		clk        = 1'b0;
		arst_n     = 1'b0;
		credit     = '0;
		exp_busy   = '0;
		for (int n = 0; n < `NOC_PORTS; n++) begin
			q_head[n]   = 0;
			q_tail[n]   = 0;
			flit_idx[n] = 0;
			crd_wr[n]   = 0;
			crd_rd[n]   = 0;
			sent_cnt[n] = 0;
			ret_cnt[n]  = 0;
			exp_lock[n] = 0;
			exp_ptr[n]  = 0;
		end
		npkt      = 0;
		late_cnt  = 0;
		late_rd   = 0;
		delivered = 0;
		cyc       = 0;
		check_cnt = 0;
		err_cnt   = 0;
		yx_pos    = '0;
		load_testdata();
		limit = npkt * `NOC_PKT_FLITS * 8 + 100;
		drive_inputs();
		repeat (3) begin
			@(posedge clk);
			#1;
			cyc++;
			drive_inputs();
		end
		arst_n = 1'b1;
		while (delivered < npkt && cyc < limit) begin
			@(posedge clk);
			#1;
			cyc++;
			drive_inputs();
		end
		if (delivered < npkt) begin
			err_cnt++;
			$display("ERROR: timeout after %0d cycles, only %0d of %0d packets delivered",
				cyc, delivered, npkt);
		end
		$display("checks %0d, errors %0d, packets delivered %0d of %0d",
			check_cnt, err_cnt, delivered, npkt);
		if (err_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/router_arbiter_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module router_arbiter_assertions (
	input wire logic                                   clk,
	input wire logic                                   arst_n_i,
	input wire arb_ctrl_pkg::req_mat_t                 req_i,
	input wire arb_ctrl_pkg::grant_t [`NOC_PORTS-1:0]  grant_i,
	input wire noc_types_pkg::port_vec_t               credit_i,
	input wire noc_types_pkg::port_vec_t               out_valid_i
);
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;

	port_vec_t multi_sel;               // input claimed by more than one output.
	int        crd_left [`NOC_PORTS];   // free downstream slots seen from the ports.

	always_comb begin
		int owners;
		for (int i = 0; i < `NOC_PORTS; i++) begin
			owners = 0;
			for (int o = 0; o < `NOC_PORTS; o++) begin
				owners += int'(grant_i[o].sel[i]);
			end
			multi_sel[i] = (owners > 1);
		end
	end

	// counts flits out and credits back at the top-level pins.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int o = 0; o < `NOC_PORTS; o++) begin
				crd_left[o] <= `NOC_CREDITS;
			end
		end else begin
			for (int o = 0; o < `NOC_PORTS; o++) begin
				crd_left[o] <= crd_left[o] - int'(out_valid_i[o]) + int'(credit_i[o]);
			end
		end
	end

	a_one_owner: assert property (@(posedge clk) disable iff (!arst_n_i) multi_sel == '0)
		else $error("input selected by several outputs, mask %b", multi_sel);

	for (genvar o = 0; o < `NOC_PORTS; o++) begin : gen_out
		a_sel_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
			grant_i[o].active && $past(grant_i[o].active) |-> $stable(grant_i[o].sel))
			else $error("output %0d select changed inside a packet", o);

		a_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
			out_valid_i[o] |-> crd_left[o] > 0)
			else $error("output %0d sent a flit with no credit", o);

		// a turn back to the arrival port is a routing error.
		a_no_uturn: assert property (@(posedge clk) disable iff (!arst_n_i) !req_i[o][o])
			else $error("input %0d requests its own direction", o);
	end

endmodule

bind router_arbiter router_arbiter_assertions u_checks (
	.clk         (clk),
	.arst_n_i    (arst_n_i),
	.req_i       (req),
	.grant_i     (grant),
	.credit_i    (credit_i),
	.out_valid_i (out_valid_o)
);

`default_nettype wire

// File: rtl/router_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module router_arbiter (
	input  wire logic                                   clk,
	input  wire logic                                   arst_n_i,
	input  wire noc_types_pkg::xy_t                     yx_pos_i,
	input  wire noc_types_pkg::port_vec_t               empty_n_i,
	input  wire noc_types_pkg::xy_t [`NOC_PORTS-1:0]    head_dest_i,
	input  wire noc_types_pkg::port_vec_t               credit_i,
	output noc_types_pkg::port_vec_t                    read_o,
	output noc_types_pkg::port_vec_t                    out_valid_o,
	output noc_types_pkg::port_dir_e [`NOC_PORTS-1:0]   out_sel_o
);
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;

	req_mat_t                  req;   // input requests per output.
	port_vec_t                 tail;  // next pop ends a packet.
	wire grant_t [`NOC_PORTS-1:0] grant;
	port_vec_t                 sent;  // one flit leaves per marked output.

	route_unit u_route (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.yx_pos_i    (yx_pos_i),
		.empty_n_i   (empty_n_i),
		.head_dest_i (head_dest_i),
		.read_i      (read_o),
		.req_o       (req),
		.tail_o      (tail)
	);

	for (genvar o = 0; o < `NOC_PORTS; o++) begin : gen_arb
		out_arbiter #(
			.PORT_IDX (o)
		) u_arb (
			.clk      (clk),
			.arst_n_i (arst_n_i),
			.req_i    (req[o]),
			.tail_i   (tail),
			.sent_i   (sent[o]),
			.credit_i (credit_i[o]),
			.grant_o  (grant[o])
		);
	end

	grant_merge u_merge (
		.grant_i   (grant),
		.empty_n_i (empty_n_i),
		.read_o    (read_o),
		.sent_o    (sent),
		.out_sel_o (out_sel_o)
	);

	assign out_valid_o = sent;

endmodule

`default_nettype wire

// File: rtl/grant_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module grant_merge (
	input  wire arb_ctrl_pkg::grant_t [`NOC_PORTS-1:0]  grant_i,
	input  wire noc_types_pkg::port_vec_t               empty_n_i,
	output noc_types_pkg::port_vec_t                    read_o,
	output noc_types_pkg::port_vec_t                    sent_o,
	output noc_types_pkg::port_dir_e [`NOC_PORTS-1:0]   out_sel_o
);
	import noc_types_pkg::*;

	// a flit moves when the output is owned, has a credit and the owner has data.
	always_comb begin
		sent_o = '0;
		for (int o = 0; o < `NOC_PORTS; o++) begin
			sent_o[o] = grant_i[o].active && grant_i[o].can_send
			            && |(grant_i[o].sel & empty_n_i);
		end
	end

	// an input belongs to one output at most, so the pops just OR together.
	always_comb begin
		read_o = '0;
		for (int o = 0; o < `NOC_PORTS; o++) begin
			if (sent_o[o]) begin
				read_o = read_o | grant_i[o].sel;
			end
		end
	end

	// one-hot owner to crossbar source code.
	always_comb begin
		for (int o = 0; o < `NOC_PORTS; o++) begin
			out_sel_o[o] = DIR_N; // idle outputs park on north.
			for (int i = 0; i < `NOC_PORTS; i++) begin
				if (grant_i[o].sel[i]) begin
					out_sel_o[o] = port_dir_e'(i);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/out_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module out_arbiter #(
	parameter int PORT_IDX = 0 // output served by this instance.
) (
	input  wire logic                      clk,
	input  wire logic                      arst_n_i,
	input  wire noc_types_pkg::port_vec_t  req_i,
	input  wire noc_types_pkg::port_vec_t  tail_i,
	input  wire logic                      sent_i,
	input  wire logic                      credit_i,
	output arb_ctrl_pkg::grant_t           grant_o
);
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;

	localparam int CRD_W = $clog2(`NOC_CREDITS + 1);

	arb_state_e       state_q;
	port_dir_e        ptr_q;    // round-robin start point.
	port_dir_e        lock_q;   // input owning the output.
	port_dir_e        pick;
	logic             pick_vld;
	port_vec_t        req_m;
	logic             pkt_done;
	logic [CRD_W-1:0] crd_q;

	// a packet never turns back to the port it came in on.
	assign req_m = req_i & ~(port_vec_t'(1) << PORT_IDX);

	// last flit of the locked packet leaves this cycle.
	assign pkt_done = sent_i && tail_i[lock_q];

	// first requester at or after the pointer, scanned backwards so the nearest wins.
	always_comb begin
		int idx;
		pick     = ptr_q;
		pick_vld = 1'b0;
		for (int k = `NOC_PORTS - 1; k >= 0; k--) begin
			idx = (int'(ptr_q) + k) % `NOC_PORTS;
			if (req_m[idx]) begin
				pick     = port_dir_e'(idx);
				pick_vld = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ARB_IDLE;
			ptr_q   <= DIR_N;
			lock_q  <= DIR_N;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (pick_vld) begin
						state_q <= ARB_BUSY;
						lock_q  <= pick;
					end
				end
				ARB_BUSY: begin
					if (pkt_done) begin
						state_q <= ARB_IDLE;
						ptr_q   <= (int'(lock_q) == `NOC_PORTS - 1) ? DIR_N
						           : port_dir_e'(lock_q + 1'b1); // skip past the served input.
					end
				end
				default: state_q <= ARB_IDLE;
			endcase
		end
	end

	// free slots downstream, a send and a returned credit cancel out.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			crd_q <= CRD_W'(`NOC_CREDITS);
		end else begin
			case ({sent_i, credit_i})
				2'b10:   crd_q <= crd_q - 1'b1;
				2'b01:   crd_q <= crd_q + 1'b1;
				default: crd_q <= crd_q;
			endcase
		end
	end

	always_comb begin
		grant_o          = '0;
		grant_o.active   = (state_q == ARB_BUSY);
		grant_o.sel      = grant_o.active ? (port_vec_t'(1) << lock_q) : '0;
		grant_o.can_send = (crd_q != '0);
	end

endmodule

`default_nettype wire

// File: rtl/route_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module route_unit (
	input  wire logic                                   clk,
	input  wire logic                                   arst_n_i,
	input  wire noc_types_pkg::xy_t                     yx_pos_i,
	input  wire noc_types_pkg::port_vec_t               empty_n_i,
	input  wire noc_types_pkg::xy_t [`NOC_PORTS-1:0]    head_dest_i,
	input  wire noc_types_pkg::port_vec_t               read_i,
	output arb_ctrl_pkg::req_mat_t                      req_o,
	output noc_types_pkg::port_vec_t                    tail_o
);
	import noc_types_pkg::*;

	localparam int CNT_W = $clog2(`NOC_PKT_FLITS);
	localparam logic [CNT_W-1:0] LAST_FLIT = CNT_W'(`NOC_PKT_FLITS - 1);

	logic [`NOC_PORTS-1:0][CNT_W-1:0] flit_cnt_q; // flits already read of the current packet.
	port_dir_e [`NOC_PORTS-1:0]       route_q;    // direction held for the body flits.
	port_dir_e [`NOC_PORTS-1:0]       hdr_dir;
	port_dir_e [`NOC_PORTS-1:0]       cur_dir;
	port_vec_t                        hdr_phase;  // input sits between packets.

	// dimension-ordered routing, x is resolved before y.
	function automatic port_dir_e xy_route(input xy_t dest, input xy_t pos);
		port_dir_e dir;
		if (dest.x > pos.x) begin
			dir = DIR_E;
		end else if (dest.x < pos.x) begin
			dir = DIR_W;
		end else if (dest.y > pos.y) begin
			dir = DIR_N;
		end else if (dest.y < pos.y) begin
			dir = DIR_S;
		end else begin
			dir = DIR_L; // arrived.
		end
		return dir;
	endfunction

	always_comb begin
		req_o  = '0;
		tail_o = '0;
		for (int i = 0; i < `NOC_PORTS; i++) begin
			hdr_phase[i] = (flit_cnt_q[i] == '0);
			hdr_dir[i]   = xy_route(head_dest_i[i], yx_pos_i);
			cur_dir[i]   = hdr_phase[i] ? hdr_dir[i] : route_q[i];
			tail_o[i]    = (flit_cnt_q[i] == LAST_FLIT);
			// a header needs a flit at the head, a body keeps its output.
			if (!hdr_phase[i] || empty_n_i[i]) begin
				req_o[cur_dir[i]][i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flit_cnt_q <= '0;
		end else begin
			for (int i = 0; i < `NOC_PORTS; i++) begin
				if (read_i[i]) begin
					flit_cnt_q[i] <= (flit_cnt_q[i] == LAST_FLIT) ? '0 : flit_cnt_q[i] + 1'b1;
				end
			end
		end
	end

	// latched when the header leaves the buffer.
	always_ff @(posedge clk) begin
		for (int i = 0; i < `NOC_PORTS; i++) begin
			if (read_i[i] && hdr_phase[i]) begin
				route_q[i] <= hdr_dir[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/arb_ctrl_pkg.sv
`default_nettype none

`include "noc_cfg.svh"

package arb_ctrl_pkg;

	// entry o holds the inputs asking for output o.
	typedef noc_types_pkg::port_vec_t [`NOC_PORTS-1:0] req_mat_t;

	// what one output arbiter tells the merge unit.
	typedef struct packed {
		logic                      active;   // a packet holds this output.
		noc_types_pkg::port_vec_t  sel;      // one-hot owning input.
		logic                      can_send; // at least one credit left.
	} grant_t;

	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_BUSY = 1'b1
	} arb_state_e;

endpackage

`default_nettype wire

// File: rtl/noc_types_pkg.sv
`default_nettype none

`include "noc_cfg.svh"

package noc_types_pkg;

	// port order also sets the crossbar select code.
	typedef enum logic [2:0] {
		DIR_N = 3'd0, // north.
		DIR_S = 3'd1, // south.
		DIR_W = 3'd2, // west.
		DIR_E = 3'd3, // east.
		DIR_L = 3'd4  // local core.
	} port_dir_e;

	typedef logic [`NOC_COORD_W-1:0] coord_t;

	// y sits in the upper half, as in the header flit.
	typedef struct packed {
		coord_t y;
		coord_t x;
	} xy_t;

	// one bit per port, indexed by port_dir_e.
	typedef logic [`NOC_PORTS-1:0] port_vec_t;

endpackage

`default_nettype wire

// File: rtl/noc_cfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// mesh router sizing, shared by the RTL and the testbench.

// ports per router: north, south, west, east, local.
`define NOC_PORTS 5

// bits in one x or y coordinate.
`define NOC_COORD_W 4

// flits per packet, header included.
`define NOC_PKT_FLITS 4

// flit slots in the downstream buffer behind each output.
`define NOC_CREDITS 4

`endif
